// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_gfx_vga_dbuf
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
JOBS ?= 4
VFLAGS ?= --binary --timing --assert -j $(JOBS)
SIM_ARGS ?=

BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard source/*.sv source/*.svh tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// File: compile.f
+incdir+source
source/fb_pkg.sv
source/fb_swap_ctrl.sv
source/vga_timing.sv
source/fb_bank_pair.sv
source/fb_writer.sv
source/pixel_stream.sv
source/gfx_vga_dbuf.sv
tests/tb_gfx_vga_dbuf.sv

// File: source/fb_bank_pair.sv
`timescale 1ns/1ps
`include "fb_consts.svh"

module fb_bank_pair
  import fb_pkg::*;
(
  input  logic                     clk,
  input  logic                     wr_en,
  input  fb_req_t                  wr_req,
  input  logic                     front_bank,
  input  logic                     rd_en,
  input  logic [`FB_ADDR_BITS-1:0] rd_addr,
  output fb_pixel_t                rd_pixel
);

  fb_pixel_t bank0 [`FB_DEPTH];
  fb_pixel_t bank1 [`FB_DEPTH];

  // read data of each bank
  fb_pixel_t q0;
  fb_pixel_t q1;

  // writes always go to the back bank
  always_ff @(posedge clk) begin
    if (wr_en) begin
      if (front_bank) begin
        bank0[wr_req.addr] <= wr_req.pixel;
      end else begin
        bank1[wr_req.addr] <= wr_req.pixel;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      q0 <= bank0[rd_addr];
      q1 <= bank1[rd_addr];
    end
  end

  // both banks are read and the select is applied after the register,
  // so a flip right after frame_start already shows on pixel (0,0)
  assign rd_pixel = front_bank ? q1 : q0;

  // a write needs a known target word
  a_wr_addr_range: assert property (
    @(posedge clk)
    wr_en |-> !$isunknown(wr_req.addr)
  );

endmodule

// File: source/fb_consts.svh
`ifndef FB_CONSTS_SVH
`define FB_CONSTS_SVH

// horizontal timing, counted in enabled cycles
`define FB_H_VISIBLE 16
`define FB_H_FRONT 2
`define FB_H_SYNC 3
`define FB_H_BACK 3
`define FB_H_WHOLE 24

// vertical timing, counted in lines
`define FB_V_VISIBLE 8
`define FB_V_FRONT 1
`define FB_V_SYNC 2
`define FB_V_BACK 1
`define FB_V_WHOLE 12

// frame-buffer geometry
`define FB_X_BITS 4
`define FB_Y_BITS 3
`define FB_ADDR_BITS 7
`define FB_DEPTH 128
`define FB_COLOR_BITS 4
`define FB_META_BITS 2

// cycles the swap waits for in-flight writes
`define FB_DRAIN_CYCLES 8

`endif

// File: source/fb_pkg.sv
`include "fb_consts.svh"

package fb_pkg;

  // one stored frame-buffer word, 14 bits
  typedef struct packed {
    logic [`FB_COLOR_BITS-1:0] red;
    logic [`FB_COLOR_BITS-1:0] grn;
    logic [`FB_COLOR_BITS-1:0] blu;
    logic [`FB_META_BITS-1:0]  meta;
  } fb_pixel_t;

  // producer request
  typedef struct packed {
    logic [`FB_X_BITS-1:0] x;
    logic [`FB_Y_BITS-1:0] y;
    fb_pixel_t             pixel;
  } gfx_write_t;

  // display output, syncs are active low
  typedef struct packed {
    logic      hsync;
    logic      vsync;
    fb_pixel_t pixel;
  } vga_out_t;

  // bank write, address already linear
  typedef struct packed {
    logic [`FB_ADDR_BITS-1:0] addr;
    fb_pixel_t                pixel;
  } fb_req_t;

endpackage

// File: source/fb_swap_ctrl.sv
`timescale 1ns/1ps
`include "fb_consts.svh"

module fb_swap_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic swap_req,
  input  logic frame_start,
  output logic write_hold,
  output logic front_bank
);

  localparam int CNT_BITS = $clog2(`FB_DRAIN_CYCLES);

  typedef enum logic [1:0] {
    IDLE,
    DRAIN,
    WAIT_FRAME
  } state_t;

  state_t              state;
  logic [CNT_BITS-1:0] drain_cnt;
  logic                swap_q;
  logic                swap_rise;

  assign swap_rise = swap_req && !swap_q;

  // producer stays blocked for the whole swap
  assign write_hold = (state != IDLE);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= IDLE;
      drain_cnt  <= '0;
      swap_q     <= 1'b0;
      front_bank <= 1'b0;
    end else begin
      swap_q <= swap_req;
      case (state)
        IDLE: begin
          // edges seen in other states are dropped
          if (swap_rise) begin
            state     <= DRAIN;
            drain_cnt <= '0;
          end
        end
        DRAIN: begin
          // give the writer pipeline time to land its last requests
          if (drain_cnt == CNT_BITS'(`FB_DRAIN_CYCLES - 1)) begin
            state <= WAIT_FRAME;
          end else begin
            drain_cnt <= drain_cnt + 1'b1;
          end
        end
        WAIT_FRAME: begin
          if (frame_start) begin
            front_bank <= !front_bank;
            state      <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // the displayed bank may only flip on a frame boundary
  a_flip_on_frame: assert property (
    @(posedge clk) disable iff (!rst_n)
    $changed(front_bank) |-> $past(frame_start)
  );

endmodule

// File: source/fb_writer.sv
`timescale 1ns/1ps
`include "fb_consts.svh"

module fb_writer
  import fb_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  gfx_write_t gfx_wr,
  input  logic       gfx_valid,
  input  logic       hold,
  output logic       ready,
  output logic       wr_en,
  output fb_req_t    wr_req
);

  logic accept;

  assign ready = !hold;
  assign accept = gfx_valid && ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_en <= 1'b0;
    end else begin
      wr_en <= accept;
    end
  end

  // row-major, y*16+x
  always_ff @(posedge clk) begin
    if (accept) begin
      wr_req.addr  <= `FB_ADDR_BITS'(gfx_wr.y * `FB_H_VISIBLE + gfx_wr.x);
      wr_req.pixel <= gfx_wr.pixel;
    end
  end

  // a stalled request must stay put until hold drops
  a_no_accept_in_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    (gfx_valid && !ready) |=> $stable(gfx_wr)
  );

endmodule

// File: source/gfx_vga_dbuf.sv
`timescale 1ns/1ps
`include "fb_consts.svh"

module gfx_vga_dbuf
  import fb_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       swap_req,
  input  gfx_write_t gfx_wr,
  input  logic       gfx_valid,
  output logic       gfx_ready,
  input  logic       vga_enable,
  output vga_out_t   vga,
  output logic       front_bank
);

  // swap control
  logic write_hold;
  logic frame_start;

  // writer to banks
  logic    wr_en;
  fb_req_t wr_req;

  // timing to banks and output stage
  logic [`FB_ADDR_BITS-1:0] rd_addr;
  logic                     visible;
  logic                     hsync;
  logic                     vsync;
  fb_pixel_t                rd_pixel;

  fb_swap_ctrl u_swap_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .swap_req   (swap_req),
    .frame_start(frame_start),
    .write_hold (write_hold),
    .front_bank (front_bank)
  );

  vga_timing u_timing (
    .clk        (clk),
    .rst_n      (rst_n),
    .enable     (vga_enable),
    .rd_addr    (rd_addr),
    .visible    (visible),
    .hsync      (hsync),
    .vsync      (vsync),
    .frame_start(frame_start)
  );

  // the writer's ready is the only gfx_ready source
  fb_writer u_writer (
    .clk      (clk),
    .rst_n    (rst_n),
    .gfx_wr   (gfx_wr),
    .gfx_valid(gfx_valid),
    .hold     (write_hold),
    .ready    (gfx_ready),
    .wr_en    (wr_en),
    .wr_req   (wr_req)
  );

  fb_bank_pair u_banks (
    .clk       (clk),
    .wr_en     (wr_en),
    .wr_req    (wr_req),
    .front_bank(front_bank),
    .rd_en     (vga_enable),
    .rd_addr   (rd_addr),
    .rd_pixel  (rd_pixel)
  );

  pixel_stream u_stream (
    .clk     (clk),
    .rst_n   (rst_n),
    .enable  (vga_enable),
    .visible (visible),
    .hsync   (hsync),
    .vsync   (vsync),
    .rd_pixel(rd_pixel),
    .vga     (vga)
  );

endmodule

// File: source/pixel_stream.sv
`timescale 1ns/1ps

module pixel_stream
  import fb_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      enable,
  input  logic      visible,
  input  logic      hsync,
  input  logic      vsync,
  input  fb_pixel_t rd_pixel,
  output vga_out_t  vga
);

  typedef struct packed {
    logic visible;
    logic hsync;
    logic vsync;
  } ctrl_t;

  // control delayed to line up with the bank read
  ctrl_t ctrl_d;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ctrl_d.visible <= 1'b0;
      ctrl_d.hsync   <= 1'b1;
      ctrl_d.vsync   <= 1'b1;
    end else if (enable) begin
      ctrl_d.visible <= visible;
      ctrl_d.hsync   <= hsync;
      ctrl_d.vsync   <= vsync;
    end
  end

  // output register, blanking forces black
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vga.hsync <= 1'b1;
      vga.vsync <= 1'b1;
      vga.pixel <= '0;
    end else if (enable) begin
      vga.hsync <= ctrl_d.hsync;
      vga.vsync <= ctrl_d.vsync;
      if (ctrl_d.visible) begin
        vga.pixel <= rd_pixel;
      end else begin
        vga.pixel <= '0;
      end
    end
  end

endmodule

// File: source/vga_timing.sv
`timescale 1ns/1ps
`include "fb_consts.svh"

module vga_timing (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     enable,
  output logic [`FB_ADDR_BITS-1:0] rd_addr,
  output logic                     visible,
  output logic                     hsync,
  output logic                     vsync,
  output logic                     frame_start
);

  localparam int H_BITS = $clog2(`FB_H_WHOLE);
  localparam int V_BITS = $clog2(`FB_V_WHOLE);

  // line order is visible, front porch, sync, back porch
  localparam int H_SYNC_START = `FB_H_VISIBLE + `FB_H_FRONT;
  localparam int H_SYNC_END = H_SYNC_START + `FB_H_SYNC;
  localparam int H_LAST = H_SYNC_END + `FB_H_BACK - 1;
  localparam int V_SYNC_START = `FB_V_VISIBLE + `FB_V_FRONT;
  localparam int V_SYNC_END = V_SYNC_START + `FB_V_SYNC;
  localparam int V_LAST = V_SYNC_END + `FB_V_BACK - 1;

  logic [H_BITS-1:0] h_cnt;
  logic [V_BITS-1:0] v_cnt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (enable) begin
      if (h_cnt == H_BITS'(H_LAST)) begin
        h_cnt <= '0;
        if (v_cnt == V_BITS'(V_LAST)) begin
          v_cnt <= '0;
        end else begin
          v_cnt <= v_cnt + 1'b1;
        end
      end else begin
        h_cnt <= h_cnt + 1'b1;
      end
    end
  end

  assign visible = (h_cnt < `FB_H_VISIBLE) && (v_cnt < `FB_V_VISIBLE);
  assign hsync = !((h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END));
  assign vsync = !((v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END));

  // out-of-range addresses only occur while blanked
  assign rd_addr = `FB_ADDR_BITS'(v_cnt * `FB_H_VISIBLE + h_cnt);

  // one pulse per frame, on the enabled cycle at the origin
  assign frame_start = enable && (h_cnt == '0) && (v_cnt == '0);

  // porch and sync widths must add up to the whole line
  a_h_in_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    h_cnt < `FB_H_WHOLE
  );

endmodule

// File: tests/tb_gfx_vga_dbuf.sv
`timescale 1ns/1ps
`include "fb_consts.svh"

module tb_gfx_vga_dbuf
  import fb_pkg::*;
();

  localparam int CLK_PERIOD = 20;
  localparam int FRAME_CYCLES = `FB_H_WHOLE * `FB_V_WHOLE;
  localparam int FRAMES_USED = 20;
  localparam int TIMEOUT_CYCLES = FRAMES_USED * FRAME_CYCLES + 1000;
  localparam int H_SYNC_START = `FB_H_VISIBLE + `FB_H_FRONT;
  localparam int V_SYNC_START = `FB_V_VISIBLE + `FB_V_FRONT;

  logic       clk;
  logic       rst_n;
  logic       swap_req;
  gfx_write_t gfx_wr;
  logic       gfx_valid;
  logic       gfx_ready;
  logic       vga_enable;
  vga_out_t   vga;
  logic       front_bank;

  // reference frame model and the last captured frame
  fb_pixel_t   model_bank [2][`FB_DEPTH];
  logic        model_front;
  fb_pixel_t   cap [`FB_DEPTH];
  logic [31:0] lcg_state;

  gfx_vga_dbuf u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .swap_req  (swap_req),
    .gfx_wr    (gfx_wr),
    .gfx_valid (gfx_valid),
    .gfx_ready (gfx_ready),
    .vga_enable(vga_enable),
    .vga       (vga),
    .front_bank(front_bank)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    abort_run("watchdog expired before all tests finished");
  end

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("RESULT: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
      abort_run("value check failed");
    end
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic fb_pixel_t rand_pixel();
    logic [31:0] r;
    r = lcg_next();
    return r[8 +: $bits(fb_pixel_t)];
  endfunction

  // advance to the next output word, skipping frozen cycles
  task automatic next_output();
    logic en;
    en = 1'b0;
    while (!en) begin
      en = vga_enable;
      @(negedge clk);
    end
  endtask

  function automatic logic sync_level(input logic vertical);
    return vertical ? vga.vsync : vga.hsync;
  endfunction

  task automatic wait_sync_rise(input logic vertical);
    logic prev;
    logic cur;
    prev = sync_level(vertical);
    next_output();
    cur = sync_level(vertical);
    while (!(!prev && cur)) begin
      prev = cur;
      next_output();
      cur = sync_level(vertical);
    end
  endtask

  task automatic capture_frame();
    int x;
    int y;
    @(negedge clk);
    wait_sync_rise(1'b1);
    // the hsync edge in the last back-porch line leads into line 0
    repeat (`FB_V_BACK - 1) wait_sync_rise(1'b0);
    for (y = 0; y < `FB_V_VISIBLE; y++) begin
      wait_sync_rise(1'b0);
      repeat (`FB_H_BACK) next_output();
      for (x = 0; x < `FB_H_VISIBLE; x++) begin
        cap[y * `FB_H_VISIBLE + x] = vga.pixel;
        next_output();
      end
    end
  endtask

  task automatic compare_frame(input logic bank);
    int i;
    for (i = 0; i < `FB_DEPTH; i++) begin
      check_equal($sformatf("vga.pixel[%0d]", i), 32'(cap[i]), 32'(model_bank[bank][i]));
    end
  endtask

  task automatic send_pixel(input int x, input int y, input fb_pixel_t pix);
    @(posedge clk);
    gfx_wr.x     <= `FB_X_BITS'(x);
    gfx_wr.y     <= `FB_Y_BITS'(y);
    gfx_wr.pixel <= pix;
    gfx_valid    <= 1'b1;
    @(negedge clk);
    while (!gfx_ready) @(negedge clk);
    // transfer completes on this edge
    @(posedge clk);
    gfx_valid <= 1'b0;
    model_bank[~model_front][y * `FB_H_VISIBLE + x] = pix;
  endtask

  task automatic fill_back_bank();
    int x;
    int y;
    for (y = 0; y < `FB_V_VISIBLE; y++) begin
      for (x = 0; x < `FB_H_VISIBLE; x++) begin
        send_pixel(x, y, rand_pixel());
      end
    end
  endtask

  task automatic start_swap();
    @(posedge clk);
    swap_req <= 1'b1;
    @(posedge clk);
    swap_req <= 1'b0;
    @(negedge clk);
    check_equal("gfx_ready", 32'(gfx_ready), 32'd0);
  endtask

  // drain plus at most one full frame of waiting
  task automatic finish_swap();
    int n;
    n = 0;
    while (front_bank === model_front) begin
      if (n > FRAME_CYCLES + `FB_DRAIN_CYCLES + 1) begin
        abort_run("front_bank did not flip within one frame after the swap request");
      end else begin
        @(negedge clk);
        n++;
      end
    end
    model_front = ~model_front;
    check_equal("gfx_ready", 32'(gfx_ready), 32'd1);
  endtask

  task automatic reset_state();
    check_equal("vga.hsync", 32'(vga.hsync), 32'd1);
    check_equal("vga.vsync", 32'(vga.vsync), 32'd1);
    check_equal("gfx_ready", 32'(gfx_ready), 32'd1);
    check_equal("front_bank", 32'(front_bank), 32'd0);
    check_equal("vga.pixel", 32'(vga.pixel), 32'd0);
  endtask

  task automatic sync_windows();
    int h;
    int v;
    logic prev;
    logic vis;
    logic exp_hs;
    logic exp_vs;
    prev = vga.vsync;
    next_output();
    while (!(prev && !vga.vsync)) begin
      prev = vga.vsync;
      next_output();
    end
    // first word of the vsync pulse is pixel 0 of the first sync line
    h = 0;
    v = V_SYNC_START;
    repeat (FRAME_CYCLES) begin
      vis = (h < `FB_H_VISIBLE) && (v < `FB_V_VISIBLE);
      exp_hs = !((h >= H_SYNC_START) && (h < H_SYNC_START + `FB_H_SYNC));
      exp_vs = !((v >= V_SYNC_START) && (v < V_SYNC_START + `FB_V_SYNC));
      check_equal("vga.hsync", 32'(vga.hsync), 32'(exp_hs));
      check_equal("vga.vsync", 32'(vga.vsync), 32'(exp_vs));
      if (!vis) begin
        check_equal("vga.pixel", 32'(vga.pixel), 32'd0);
      end
      next_output();
      h++;
      if (h == `FB_H_WHOLE) begin
        h = 0;
        v = (v + 1) % `FB_V_WHOLE;
      end
    end
  endtask

  task automatic first_swap();
    fill_back_bank();
    start_swap();
    finish_swap();
    check_equal("front_bank", 32'(front_bank), 32'd1);
    capture_frame();
    compare_frame(model_front);
  endtask

  // back-bank writes run while the front bank is on screen
  task automatic back_bank_isolation();
    int rx;
    int ry;
    fork
      capture_frame();
      begin
        fill_back_bank();
        repeat (8) begin
          rx = int'(lcg_next() % `FB_H_VISIBLE);
          ry = int'(lcg_next() % `FB_V_VISIBLE);
          send_pixel(rx, ry, rand_pixel());
        end
      end
    join
    compare_frame(model_front);
  endtask

  task automatic freeze_output(input int lead, input int len);
    vga_out_t held;
    repeat (lead) @(negedge clk);
    @(posedge clk);
    vga_enable <= 1'b0;
    @(negedge clk);
    held = vga;
    repeat (len) begin
      @(negedge clk);
      check_equal("vga", 32'(vga), 32'(held));
    end
    @(posedge clk);
    vga_enable <= 1'b1;
  endtask

  task automatic enable_freeze();
    int lead;
    int len;
    lead = 20 + int'(lcg_next() % 32'd150);
    len = 2 + int'(lcg_next() % 32'd30);
    fork
      capture_frame();
      freeze_output(lead, len);
    join
    compare_frame(model_front);
  endtask

  task automatic second_swap();
    int hx;
    int hy;
    fb_pixel_t hpix;
    hx = int'(lcg_next() % `FB_H_VISIBLE);
    hy = int'(lcg_next() % `FB_V_VISIBLE);
    // current front bank becomes the back bank, so make the word differ
    hpix = ~model_bank[model_front][hy * `FB_H_VISIBLE + hx];
    start_swap();
    fork
      finish_swap();
      send_pixel(hx, hy, hpix);
    join
    check_equal("front_bank", 32'(front_bank), 32'd0);
    capture_frame();
    compare_frame(model_front);
    // held write only shows after the following swap
    start_swap();
    finish_swap();
    capture_frame();
    compare_frame(model_front);
  endtask

  initial begin
    rst_n = 1'b0;
    swap_req = 1'b0;
    gfx_wr = '0;
    gfx_valid = 1'b0;
    vga_enable = 1'b1;
    lcg_state = 32'd43797;
    model_front = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    reset_state();
    sync_windows();
    first_swap();
    back_bank_isolation();
    enable_freeze();
    second_swap();
    $display("RESULT: PASS");
    $finish;
  end

endmodule
